// ==== Bender.yml ====
package:
  name: downsampler

sources:
  # packages first, then the RTL bottom up
  - logic/lvds_pkg.sv
  - logic/merge_pkg.sv
  - logic/config_sync.sv
  - logic/lane_decoder.sv
  - logic/sample_merger.sv
  - logic/downsampler_top.sv

  # testbench, includes tb_model.svh
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_downsampler_top.sv

// ==== logic/config_sync.sv ====
// config_sync: resync of the configuration inputs and merge code decode
`timescale 1ns/1ps

module config_sync (
   input  logic                   clklvds,
   input  logic                   rst,
   input  logic [7:0]             channeltype,       // bit 1 selects swapped inputs
   input  logic [7:0]             downsamplemerging, // merge factor as a plain number
   input  logic                   highres,
   output merge_pkg::merge_cfg_t  cfg
);

   merge_pkg::merge_mode_e mode_dec;

   // only factors 1, 2 and 4 are built in single channel mode
   always_comb begin
      case (downsamplemerging)
         8'd1:    mode_dec = merge_pkg::merge_1;
         8'd2:    mode_dec = merge_pkg::merge_2;
         8'd4:    mode_dec = merge_pkg::merge_4;
         default: mode_dec = merge_pkg::merge_hold;
      endcase
   end

   // inputs come from a slower domain and change rarely
   always_ff @(posedge clklvds) begin
      if (rst) begin
         cfg <= '0;
      end else begin
         cfg.swap    <= channeltype[1]; // oversampling, swapped
         cfg.mode    <= mode_dec;
         cfg.highres <= highres;
      end
   end

   // the lane decoders and the merger case statement rely on a defined configuration
   a_mode_known: assert property (@(posedge clklvds) disable iff (rst)
      !$isunknown(cfg))
      else $error("cfg is unknown after reset");

endmodule

// ==== logic/downsampler_top.sv ====
// downsampler_top: config resync, four lane decoders and the sample merger
`timescale 1ns/1ps

module downsampler_top (
   input  logic                                           clklvds,
   input  logic                                           rst,
   input  lvds_pkg::lane_word_t [lvds_pkg::n_lanes-1:0]   lvds_words,
   input  logic [7:0]                                     channeltype,
   input  logic [7:0]                                     downsamplemerging,
   input  logic                                           highres,
   output lvds_pkg::frame_t                               samples
);

   merge_pkg::merge_cfg_t                                 cfg;
   lvds_pkg::lane_samples_t [lvds_pkg::n_lanes-1:0]       lane_out; // decoded lanes

   config_sync i_config_sync (
      .clklvds           (clklvds),
      .rst               (rst),
      .channeltype       (channeltype),
      .downsamplemerging (downsamplemerging),
      .highres           (highres),
      .cfg               (cfg)
   );

   // one decoder per LVDS input
   for (genvar k = 0; k < lvds_pkg::n_lanes; k++) begin : g_lane
      lane_decoder i_lane_decoder (
         .clklvds (clklvds),
         .rst     (rst),
         .word    (lvds_words[k]),
         .swap    (cfg.swap),
         .samples (lane_out[k])
      );
   end

   sample_merger i_sample_merger (
      .clklvds (clklvds),
      .rst     (rst),
      .lanes   (lane_out),
      .mode    (cfg.mode),
      .highres (cfg.highres),
      .frame   (samples)
   );

endmodule

// ==== logic/lane_decoder.sv ====
// lane_decoder: reordering of one lane word into ten samples, saturating inversion
`timescale 1ns/1ps

module lane_decoder (
   input  logic                       clklvds,
   input  logic                       rst,
   input  lvds_pkg::lane_word_t       word,
   input  logic                       swap,    // invert every sample
   output lvds_pkg::lane_samples_t    samples
);

   lvds_pkg::lane_samples_t gathered;  // bits in sample order
   lvds_pkg::lane_samples_t ordered_q; // first pipeline stage
   logic                    has_min;   // some output sample is -2048

   // negate with saturation, -2048 maps to +2047
   function automatic lvds_pkg::sample_t sat_negate(input lvds_pkg::sample_t s);
      if (s == lvds_pkg::sample_min) begin
         return lvds_pkg::sample_max;
      end
      return -s;
   endfunction

   // the serializer interleaves the samples bit by bit
   always_comb begin
      for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
         for (int b = 0; b < lvds_pkg::sample_bits; b++) begin
            gathered[i][b] = word[lvds_pkg::samples_per_lane*b + i];
         end
      end
   end

   always_ff @(posedge clklvds) begin
      if (rst) begin
         ordered_q <= '0;
         samples   <= '0;
      end else begin
         ordered_q <= gathered;
         for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
            if (swap) begin
               samples[i] <= sat_negate(ordered_q[i]); // swapped inputs, invert
            end else begin
               samples[i] <= ordered_q[i];
            end
         end
      end
   end

   always_comb begin
      has_min = 1'b0;
      for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
         has_min = has_min | (samples[i] == lvds_pkg::sample_min);
      end
   end

   // an inverted frame must never carry the one value that has no negation
   a_no_min_when_swapped: assert property (@(posedge clklvds) disable iff (rst)
      swap |=> !has_min)
      else $error("lane sample equals -2048 with swap set");

endmodule

// ==== logic/lvds_pkg.sv ====
// lvds_pkg: LVDS lane word format, sample and frame types, sample limits
package lvds_pkg;

   localparam int n_lanes          = 4;   // LVDS deserializer inputs
   localparam int samples_per_lane = 10;  // samples per lane per clklvds cycle
   localparam int sample_bits      = 12;  // ADC resolution
   localparam int lane_bits        = 140; // deserializer word, clk/str bits in 120..139

   // raw deserializer word, sample i bit b sits at word bit 10*b+i
   typedef logic [lane_bits-1:0] lane_word_t;

   // one signed ADC sample, bit 11 is the msb
   typedef logic signed [sample_bits-1:0] sample_t;

   // ten samples of one lane, index is the sample number
   typedef sample_t [samples_per_lane-1:0] lane_samples_t;

   // output frame of forty samples
   typedef sample_t [n_lanes*samples_per_lane-1:0] frame_t;

   // two's complement range, -2048 has no positive counterpart
   localparam sample_t sample_min = -12'sd2048;
   localparam sample_t sample_max = 12'sd2047;

endpackage

// ==== logic/merge_pkg.sv ====
// merge_pkg: merge mode enum, decoded configuration struct, highres sum type
package merge_pkg;

   // supported single channel merge factors, anything else freezes the frame
   typedef enum logic [1:0] {
      merge_1    = 2'd0, // full rate
      merge_2    = 2'd1, // every other sample
      merge_4    = 2'd2, // every fourth sample
      merge_hold = 2'd3  // unsupported code
   } merge_mode_e;

   // room for the sum of four 12-bit samples
   localparam int sum_bits = 14;

   typedef logic signed [sum_bits-1:0] sum_t;

   // configuration after resync and decode
   typedef struct packed {
      logic        swap;    // oversampling input config, samples inverted
      merge_mode_e mode;    // decoded merge factor
      logic        highres; // average instead of select
   } merge_cfg_t;

endpackage

// ==== logic/sample_merger.sv ====
// sample_merger: single channel merging by 1, 2 or 4, highres averaging, history shift
`timescale 1ns/1ps

module sample_merger (
   input  logic                                              clklvds,
   input  logic                                              rst,
   input  lvds_pkg::lane_samples_t [lvds_pkg::n_lanes-1:0]   lanes,
   input  merge_pkg::merge_mode_e                            mode,
   input  logic                                              highres,
   output lvds_pkg::frame_t                                  frame
);

   localparam int n_pairs = 2 * lvds_pkg::samples_per_lane; // merge_2 slots per cycle

   lvds_pkg::frame_t                                   align_q; // merge_1 layout
   merge_pkg::sum_t [n_pairs-1:0]                      sum2_q;  // pair sums for merge_2
   merge_pkg::sum_t [lvds_pkg::samples_per_lane-1:0]   sum4_q;  // quad sums for merge_4

   // first stage, full rate ordering and the highres sums
   always_ff @(posedge clklvds) begin
      if (rst) begin
         align_q <= '0;
         sum2_q  <= '0;
         sum4_q  <= '0;
      end else begin
         for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
            // lane 3 holds the oldest sample of each group of four
            for (int k = 0; k < lvds_pkg::n_lanes; k++) begin
               align_q[lvds_pkg::n_lanes*i + k] <= lanes[lvds_pkg::n_lanes-1-k][i];
            end

            sum2_q[2*i]     <= merge_pkg::sum_t'(lanes[2][i]) +
                               merge_pkg::sum_t'(lanes[3][i]);
            sum2_q[2*i + 1] <= merge_pkg::sum_t'(lanes[0][i]) +
                               merge_pkg::sum_t'(lanes[1][i]);

            sum4_q[i] <= merge_pkg::sum_t'(lanes[0][i]) +
                         merge_pkg::sum_t'(lanes[1][i]) +
                         merge_pkg::sum_t'(lanes[2][i]) +
                         merge_pkg::sum_t'(lanes[3][i]);
         end
      end
   end

   // output frame, new merged samples at the bottom, older ones shifted up
   always_ff @(posedge clklvds) begin
      if (rst) begin
         frame <= '0;
      end else begin
         case (mode)
            merge_pkg::merge_1: begin
               frame <= align_q; // highres has no meaning at full rate
            end

            merge_pkg::merge_2: begin
               for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
                  if (highres) begin
                     frame[2*i]     <= sum2_q[2*i][12:1];     // divide by 2
                     frame[2*i + 1] <= sum2_q[2*i + 1][12:1];
                  end else begin
                     frame[2*i]     <= lanes[2][i];
                     frame[2*i + 1] <= lanes[0][i];
                  end
               end
               for (int n = 0; n < n_pairs; n++) begin
                  frame[n_pairs + n] <= frame[n]; // first 20 into second 20
               end
            end

            merge_pkg::merge_4: begin
               for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
                  if (highres) begin
                     frame[i] <= sum4_q[i][13:2]; // divide by 4
                  end else begin
                     frame[i] <= lanes[0][i];
                  end
               end
               // three groups of ten move up by one group
               for (int n = 0; n < 3*lvds_pkg::samples_per_lane; n++) begin
                  frame[lvds_pkg::samples_per_lane + n] <= frame[n];
               end
            end

            default: begin
               frame <= frame; // unsupported merge code, keep last frame
            end
         endcase
      end
   end

   // the history groups form one shift chain through the frame
   a_merge4_shift: assert property (@(posedge clklvds) disable iff (rst)
      (mode == merge_pkg::merge_4) |=>
         (frame[4*lvds_pkg::samples_per_lane-1:lvds_pkg::samples_per_lane] ==
          $past(frame[3*lvds_pkg::samples_per_lane-1:0])))
      else $error("merge_4 history slots did not shift by one group");

endmodule

// ==== sources.f ====
+incdir+testbench
logic/lvds_pkg.sv
logic/merge_pkg.sv
logic/config_sync.sv
logic/lane_decoder.sv
logic/sample_merger.sv
logic/downsampler_top.sv
testbench/tb_downsampler_top.sv

// ==== testbench/tb_model.svh ====
// tb_model: sample extraction, saturating inversion and expected frame for each merge factor
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// bit b of sample i travels at word bit 10*b+i
function automatic int word_sample(input lvds_pkg::lane_word_t w, input int i);
   logic signed [lvds_pkg::sample_bits-1:0] s;
   for (int b = 0; b < lvds_pkg::sample_bits; b++) begin
      s[b] = w[lvds_pkg::samples_per_lane*b + i];
   end
   return int'(s); // sign extended
endfunction

// inverse of word_sample, places a value into one sample position
function automatic lvds_pkg::lane_word_t put_sample(input lvds_pkg::lane_word_t w,
                                                    input int i, input int v);
   lvds_pkg::lane_word_t r;
   logic [lvds_pkg::sample_bits-1:0] bits;
   r    = w;
   bits = v[lvds_pkg::sample_bits-1:0];
   for (int b = 0; b < lvds_pkg::sample_bits; b++) begin
      r[lvds_pkg::samples_per_lane*b + i] = bits[b];
   end
   return r;
endfunction

// negation clamped to the positive 12-bit limit
function automatic int invert_value(input int v);
   int n;
   n = -v;
   if (n > 2047) begin
      n = 2047; // -2048 has no positive twin
   end
   return n;
endfunction

// expected steady frame, unsupported codes keep the previous frame
function automatic lvds_pkg::frame_t model_frame(
   input lvds_pkg::lane_word_t [lvds_pkg::n_lanes-1:0] words,
   input logic swap, input logic [7:0] code, input logic hr,
   input lvds_pkg::frame_t prev);
   int               lane [lvds_pkg::n_lanes][lvds_pkg::samples_per_lane];
   lvds_pkg::frame_t f;
   f = prev;
   for (int l = 0; l < lvds_pkg::n_lanes; l++) begin
      for (int i = 0; i < lvds_pkg::samples_per_lane; i++) begin
         lane[l][i] = word_sample(words[l], i);
         if (swap) begin
            lane[l][i] = invert_value(lane[l][i]);
         end
      end
   end
   case (code)
      8'd1: begin
         for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 4; k++) begin
               f[4*i + k] = lvds_pkg::sample_t'(lane[3-k][i]); // lane 3 first
            end
         end
      end
      8'd2: begin
         for (int i = 0; i < 10; i++) begin
            f[2*i]     = lvds_pkg::sample_t'(hr ? (lane[2][i] + lane[3][i]) >>> 1 : lane[2][i]);
            f[2*i + 1] = lvds_pkg::sample_t'(hr ? (lane[0][i] + lane[1][i]) >>> 1 : lane[0][i]);
         end
         for (int n = 0; n < 20; n++) begin
            f[20 + n] = f[n]; // history equals the new half at steady state
         end
      end
      8'd4: begin
         for (int i = 0; i < 10; i++) begin
            f[i] = lvds_pkg::sample_t'(hr ? (lane[0][i] + lane[1][i] + lane[2][i]
                                             + lane[3][i]) >>> 2 : lane[0][i]);
         end
         for (int g = 1; g < 4; g++) begin
            for (int n = 0; n < 10; n++) begin
               f[10*g + n] = f[n];
            end
         end
      end
      default: begin
      end
   endcase
   return f;
endfunction

`endif

// ==== testbench/tb_downsampler_top.sv ====
// tb_downsampler_top: clock, reset, random config phases, watchdog and assertion checks
`timescale 1ns/1ps

module tb_downsampler_top;

   localparam int period_ns     = 40;
   localparam int reset_cycles  = 8;
   localparam int settle_cycles = 12; // longer than the 8 cycle settling time
   localparam int check_cycles  = 4;
   localparam int n_phases      = 11;
   localparam int seed          = 65733;
   localparam int timeout_ns    = (reset_cycles + 3 + n_phases*(1 + settle_cycles + check_cycles))
                                  * period_ns + 50*period_ns;
   localparam int forced_lane   = 1;  // carries the -2048 sample in the swap phase
   localparam int forced_index  = 3;
   localparam int forced_slot   = 4*forced_index + (3 - forced_lane); // merge_1 position
   localparam lvds_pkg::sample_t sat_positive = 12'sd2047; // what -2048 inverts to

   logic                                          clklvds = 1'b0;
   logic                                          rst;
   lvds_pkg::lane_word_t [lvds_pkg::n_lanes-1:0]  lvds_words;
   logic [7:0]                                    channeltype;
   logic [7:0]                                    downsamplemerging;
   logic                                          highres;
   lvds_pkg::frame_t                              samples;

   lvds_pkg::frame_t expected;    // model frame for the inputs now driven
   lvds_pkg::frame_t held_frame;  // steady frame of the previous phase
   logic             check;       // inputs settled, compare now
   logic             forced_min;
   logic             rst_d1 = 1'b0;
   logic             rst_d2 = 1'b0;

   `include "tb_model.svh"

   downsampler_top i_downsampler_top (
      .clklvds           (clklvds),
      .rst               (rst),
      .lvds_words        (lvds_words),
      .channeltype       (channeltype),
      .downsamplemerging (downsamplemerging),
      .highres           (highres),
      .samples           (samples)
   );

   always #(period_ns/2) clklvds = ~clklvds;

   always @(posedge clklvds) begin
      rst_d1 <= rst;
      rst_d2 <= rst_d1; // covers the first cycle after release
   end

   always_comb begin
      expected = model_frame(lvds_words, channeltype[1], downsamplemerging, highres, held_frame);
   end

   task automatic end_with_failure();
      $display("TESTS FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_slot_error(input string signal_name, input int slot,
                                    input lvds_pkg::sample_t exp, input lvds_pkg::sample_t got);
      $display("[ERROR] %0t ns %s[%0d] expected %0d got %0d",
               $time, signal_name, slot, exp, got);
      end_with_failure();
   endtask

   // reports the lowest slot that differs
   task automatic report_frame_error(input lvds_pkg::frame_t exp, input lvds_pkg::frame_t got);
      int slot;
      slot = 0;
      for (int s = 4*lvds_pkg::samples_per_lane - 1; s >= 0; s--) begin
         if (exp[s] != got[s]) begin
            slot = s;
         end
      end
      report_slot_error("samples", slot, exp[slot], got[slot]);
   endtask

   function automatic lvds_pkg::sample_t slot_of(input lvds_pkg::frame_t f, input int s);
      return f[s];
   endfunction

   // copies the lowest width slots into every higher group
   function automatic lvds_pkg::frame_t repeat_low(input lvds_pkg::frame_t f, input int width);
      lvds_pkg::frame_t r;
      r = f;
      for (int n = width; n < 4*lvds_pkg::samples_per_lane; n++) begin
         r[n] = f[n % width];
      end
      return r;
   endfunction

   function automatic lvds_pkg::lane_word_t random_word();
      logic [159:0] raw;
      raw = {$urandom, $urandom, $urandom, $urandom, $urandom};
      return raw[lvds_pkg::lane_bits-1:0]; // clock and strobe bits random too
   endfunction

   a_reset_zero: assert property (@(posedge clklvds) (rst_d1 || rst_d2) |-> samples == '0)
      else report_frame_error('0, $sampled(samples));

   a_frame_match: assert property (@(posedge clklvds) check |-> samples == expected)
      else report_frame_error($sampled(expected), $sampled(samples));

   a_merge2_history: assert property (@(posedge clklvds)
      check && downsamplemerging == 8'd2 |-> samples == repeat_low(expected, 20))
      else report_frame_error(repeat_low($sampled(expected), 20), $sampled(samples));

   a_merge4_history: assert property (@(posedge clklvds)
      check && downsamplemerging == 8'd4 |-> samples == repeat_low(expected, 10))
      else report_frame_error(repeat_low($sampled(expected), 10), $sampled(samples));

   a_swap_saturated: assert property (@(posedge clklvds)
      check && forced_min |-> samples[forced_slot] == sat_positive)
      else report_slot_error("samples", forced_slot, sat_positive,
                             slot_of($sampled(samples), forced_slot));

   // one configuration with fresh lane words, settle, then compare for a few cycles
   task automatic run_phase(input logic [7:0] code, input logic swap, input logic hr,
                            input logic force_min, input logic churn);
      lvds_pkg::lane_word_t [lvds_pkg::n_lanes-1:0] words;
      logic [7:0]                                   ctype;
      for (int k = 0; k < lvds_pkg::n_lanes; k++) begin
         words[k] = random_word();
      end
      if (force_min) begin
         words[forced_lane] = put_sample(words[forced_lane], forced_index, -2048);
      end
      ctype    = 8'($urandom); // only bit 1 has a meaning
      ctype[1] = swap;
      @(posedge clklvds);
      held_frame        <= expected;
      check             <= 1'b0;
      lvds_words        <= words;
      channeltype       <= ctype;
      downsamplemerging <= code;
      highres           <= hr;
      forced_min        <= force_min;
      repeat (settle_cycles) begin
         @(posedge clklvds);
         if (churn) begin
            lvds_words <= {random_word(), random_word(), random_word(), random_word()};
         end
      end
      check <= 1'b1;
      repeat (check_cycles) begin
         @(posedge clklvds);
         if (churn) begin
            lvds_words <= {random_word(), random_word(), random_word(), random_word()};
         end
      end
   endtask

   initial begin
      void'($urandom(seed));
      rst               = 1'b1;
      lvds_words        = {random_word(), random_word(), random_word(), random_word()};
      channeltype       = 8'd0;
      downsamplemerging = 8'd1;
      highres           = 1'b0;
      held_frame        = '0;
      check             = 1'b0;
      forced_min        = 1'b0;
      repeat (reset_cycles) @(posedge clklvds);
      rst <= 1'b0;
      repeat (2) @(posedge clklvds);

      run_phase(8'd1, 1'b0, 1'b0, 1'b0, 1'b0); // full rate ordering
      run_phase(8'd1, 1'b0, 1'b1, 1'b0, 1'b0); // highres has no effect
      run_phase(8'd1, 1'b1, 1'b0, 1'b1, 1'b0); // inverted, -2048 saturates
      run_phase(8'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      run_phase(8'd2, 1'b0, 1'b1, 1'b0, 1'b0);
      run_phase(8'd4, 1'b0, 1'b0, 1'b0, 1'b0);
      run_phase(8'd4, 1'b0, 1'b1, 1'b0, 1'b0);
      run_phase(8'd8, 1'b0, 1'b1, 1'b0, 1'b1); // unsupported code freezes the frame
      run_phase(8'd2, 1'b1, 1'b1, 1'b0, 1'b0);
      run_phase(8'd0, 1'b1, 1'b1, 1'b0, 1'b1);
      run_phase(8'd4, 1'b1, 1'b1, 1'b0, 1'b0);

      @(posedge clklvds);
      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("watchdog expired, the test phases did not finish within %0d ns", timeout_ns);
      end_with_failure();
   end

endmodule
